// ==== common/bch_pkg.sv ====
`default_nettype none

package bch_pkg;

	//==================================================
	// field and code sizes
	//==================================================
	parameter int GF_M = 6;                            // GF(2^6)
	parameter int CODE_N = 63;                         // 2^GF_M - 1
	parameter logic [GF_M:0] PRIM_POLY = 7'b100_0011;  // x^6 + x + 1

	typedef logic [GF_M-1:0] gf_elem_t;
	typedef logic [5:0] loc_t;                         // bit position 0 .. 62

	// error locator scaled by S1, degree as predicted from the syndromes
	typedef struct packed {
		gf_elem_t c0;
		gf_elem_t c1;
		gf_elem_t c2;
		logic [1:0] degree;
	} locator_t;

	//==================================================
	// field arithmetic
	//==================================================
	// one multiply by alpha
	function automatic gf_elem_t gf_xtime(input gf_elem_t a);
		gf_elem_t r;
		r = {a[GF_M-2:0], 1'b0};
		if (a[GF_M-1]) begin
			r = r ^ PRIM_POLY[GF_M-1:0];  // reduce x^6 -> x + 1
		end
		return r;
	endfunction

	// shift and add, reduced every step
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i]) begin
				acc = acc ^ sh;
			end
			sh = gf_xtime(sh);
		end
		return acc;
	endfunction

	// alpha^e, negative exponents wrap around the field order
	function automatic gf_elem_t gf_pow(input int e);
		int k;
		gf_elem_t r;
		k = e % CODE_N;
		if (k < 0) begin
			k = k + CODE_N;
		end
		r = gf_elem_t'(1);
		for (int i = 0; i < k; i++) begin
			r = gf_xtime(r);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/bch_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_control #(
	parameter int BEAT_W = 8
) (
	input  wire logic i_clk,
	input  wire logic i_rst_n,
	input  wire logic i_set,
	input  wire logic i_finish,
	output logic      o_ready,
	output logic      o_syn_clear,
	output logic      o_syn_en,
	output logic      o_syn_valid
);

	localparam int NUM_BEATS = 64 / BEAT_W;                       // beats per codeword
	localparam int CNT_W = (NUM_BEATS > 1) ? $clog2(NUM_BEATS) : 1;
	localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(NUM_BEATS - 1);

	logic             ready_q;
	logic             beat_active;   // beats 1 .. NUM_BEATS-1
	logic [CNT_W-1:0] beat_cnt;
	logic             syn_valid_q;
	logic             accept;
	logic             last_beat;

	assign accept = i_set & ready_q;  // beat 0 is on i_data now
	assign last_beat = (accept && (NUM_BEATS == 1)) || (beat_active && (beat_cnt == LAST_BEAT));

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_q <= 1'b1;
			beat_active <= 1'b0;
			beat_cnt <= '0;
			syn_valid_q <= 1'b0;
		end else begin
			syn_valid_q <= last_beat;  // syndromes settle one cycle later
			if (accept) begin
				ready_q <= 1'b0;
			end else if (i_finish) begin
				ready_q <= 1'b1;
			end
			if (accept && (NUM_BEATS > 1)) begin
				beat_active <= 1'b1;
				beat_cnt <= CNT_W'(1);
			end else if (beat_active) begin
				if (beat_cnt == LAST_BEAT) begin
					beat_active <= 1'b0;
				end
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	assign o_ready = ready_q;
	assign o_syn_clear = accept;
	assign o_syn_en = accept | beat_active;
	assign o_syn_valid = syn_valid_q;

	// no beat is taken in while waiting for a block
	a_no_en_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		ready_q && !accept |-> !o_syn_en);

	// the syndrome strobe follows acceptance after a full codeword
	a_syn_valid_time: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		accept |-> ##NUM_BEATS o_syn_valid);

endmodule

`default_nettype wire

// ==== syndrome/syndrome_accum.sv ====
`timescale 1ns/10ps
`default_nettype none

module syndrome_accum import bch_pkg::*; #(
	parameter int BEAT_W = 8,
	parameter int POWER = 1                   // odd syndrome index
) (
	input  wire logic              i_clk,
	input  wire logic              i_rst_n,
	input  wire logic              i_clear,
	input  wire logic              i_en,
	input  wire logic [BEAT_W-1:0] i_data,
	output gf_elem_t               o_syndrome
);

	// running value moves up by one whole beat of positions
	localparam gf_elem_t STEP = gf_pow(POWER * BEAT_W);

	gf_elem_t [BEAT_W-1:0] term;
	gf_elem_t              beat_sum;
	gf_elem_t              base;
	gf_elem_t              syn_q;

	//==================================================
	// per-bit weights alpha^(POWER*i)
	//==================================================
	for (genvar g = 0; g < BEAT_W; g++) begin : g_term
		localparam gf_elem_t WEIGHT = gf_pow(POWER * g);
		assign term[g] = i_data[g] ? WEIGHT : '0;
	end

	always_comb begin
		beat_sum = '0;
		for (int i = 0; i < BEAT_W; i++) begin
			beat_sum = beat_sum ^ term[i];
		end
	end

	// Horner step, a clear beat starts from zero
	assign base = i_clear ? '0 : gf_mul(syn_q, STEP);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			syn_q <= '0;
		end else if (i_en) begin
			syn_q <= base ^ beat_sum;
		end
	end

	assign o_syndrome = syn_q;

endmodule

`default_nettype wire

// ==== rtl/key_equation.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_equation import bch_pkg::*; (
	input  wire logic     i_clk,
	input  wire logic     i_rst_n,
	input  wire gf_elem_t i_s1,
	input  wire gf_elem_t i_s3,
	input  wire logic     i_syn_valid,
	output locator_t      o_locator,
	output logic          o_loc_valid
);

	gf_elem_t s1_sq;
	gf_elem_t s1_cu;
	locator_t loc_d;
	locator_t loc_q;
	logic     valid_q;

	//==================================================
	// t = 2 locator, scaled by S1 to avoid a division
	//==================================================
	assign s1_sq = gf_mul(i_s1, i_s1);
	assign s1_cu = gf_mul(s1_sq, i_s1);

	always_comb begin
		loc_d.c0 = i_s1;
		loc_d.c1 = s1_sq;
		loc_d.c2 = i_s3 ^ s1_cu;
		if ((i_s1 == '0) && (i_s3 == '0)) begin
			loc_d.degree = 2'd0;  // clean word
		end else if ((i_s1 != '0) && (i_s3 == s1_cu)) begin
			loc_d.degree = 2'd1;  // single error
		end else begin
			loc_d.degree = 2'd2;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_syn_valid) begin
			loc_q <= loc_d;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_syn_valid;
		end
	end

	assign o_locator = loc_q;
	assign o_loc_valid = valid_q;

endmodule

`default_nettype wire

// ==== chien_search/chien_search.sv ====
`timescale 1ns/10ps
`default_nettype none

module chien_search import bch_pkg::*; (
	input  wire logic     i_clk,
	input  wire logic     i_rst_n,
	input  wire locator_t i_locator,
	input  wire logic     i_loc_valid,
	output loc_t          o_err_loc,
	output logic          o_err_valid,
	output logic          o_finish,
	output logic [1:0]    o_num_err,
	output logic          o_uncorrectable
);

	localparam gf_elem_t ALPHA_INV1 = gf_pow(-1);
	localparam gf_elem_t ALPHA_INV2 = gf_pow(-2);
	localparam loc_t LAST_POS = loc_t'(CODE_N - 1);

	gf_elem_t   term0;
	gf_elem_t   term1;
	gf_elem_t   term2;
	logic [1:0] degree_q;
	logic       scan_active;
	logic       last_q;        // count now includes the last position
	loc_t       pos;
	logic [1:0] cnt_q;
	logic       root;
	logic       err_valid_q;
	loc_t       err_loc_q;
	logic       finish_q;
	logic [1:0] num_err_q;
	logic       uncorr_q;

	// an all-zero locator has no error, not 63 roots
	assign root = scan_active && ((term0 ^ term1 ^ term2) == '0) && (degree_q != 2'd0);

	//==================================================
	// term registers, one position per cycle
	//==================================================
	always_ff @(posedge i_clk) begin
		if (i_loc_valid) begin
			term0 <= i_locator.c0;
			term1 <= i_locator.c1;
			term2 <= i_locator.c2;
			degree_q <= i_locator.degree;
		end else if (scan_active) begin
			term1 <= gf_mul(term1, ALPHA_INV1);  // c1 * alpha^-j
			term2 <= gf_mul(term2, ALPHA_INV2);  // c2 * alpha^-2j
		end
		err_loc_q <= pos;
		if (last_q) begin
			num_err_q <= cnt_q;
			uncorr_q <= (cnt_q != degree_q);
		end
	end

	//==================================================
	// scan control and strobes
	//==================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			scan_active <= 1'b0;
			last_q <= 1'b0;
			pos <= '0;
			cnt_q <= '0;
			err_valid_q <= 1'b0;
			finish_q <= 1'b0;
		end else begin
			err_valid_q <= root;
			finish_q <= last_q;
			last_q <= scan_active && (pos == LAST_POS);
			if (i_loc_valid) begin
				scan_active <= 1'b1;
				pos <= '0;
				cnt_q <= '0;
			end else if (scan_active) begin
				if (pos == LAST_POS) begin
					scan_active <= 1'b0;
				end
				pos <= pos + 1'b1;
				cnt_q <= cnt_q + {1'b0, root};  // at most two roots
			end
		end
	end

	assign o_err_loc = err_loc_q;
	assign o_err_valid = err_valid_q;
	assign o_finish = finish_q;
	assign o_num_err = num_err_q;
	assign o_uncorrectable = uncorr_q;

	a_err_not_finish: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_err_valid && o_finish));

	// one block in flight, a new locator only after the scan has wound down
	a_no_load_mid_scan: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_loc_valid |-> !scan_active && !last_q);

endmodule

`default_nettype wire

// ==== rtl/bch_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module bch_decoder import bch_pkg::*; #(
	parameter int BEAT_W = 8                   // bits per input beat
) (
	input  wire logic              i_clk,
	input  wire logic              i_rst_n,
	input  wire logic              i_set,
	input  wire logic [BEAT_W-1:0] i_data,
	output logic                   o_ready,
	output loc_t                   o_err_loc,
	output logic                   o_err_valid,
	output logic                   o_finish,
	output logic [1:0]             o_num_err,
	output logic                   o_uncorrectable
);

	logic     syn_clear;
	logic     syn_en;
	logic     syn_valid;
	gf_elem_t syn_s1;
	gf_elem_t syn_s3;
	locator_t locator;
	logic     loc_valid;

	//==================================================
	// control
	//==================================================
	bch_control #(
		.BEAT_W(BEAT_W)
	) u_control (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_set      (i_set),
		.i_finish   (o_finish),               // reopens ready
		.o_ready    (o_ready),
		.o_syn_clear(syn_clear),
		.o_syn_en   (syn_en),
		.o_syn_valid(syn_valid)
	);

	//==================================================
	// syndromes S1 and S3
	//==================================================
	syndrome_accum #(
		.BEAT_W(BEAT_W),
		.POWER (1)
	) u_syndrome_s1 (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_clear   (syn_clear),
		.i_en      (syn_en),
		.i_data    (i_data),
		.o_syndrome(syn_s1)
	);

	syndrome_accum #(
		.BEAT_W(BEAT_W),
		.POWER (3)
	) u_syndrome_s3 (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_clear   (syn_clear),
		.i_en      (syn_en),
		.i_data    (i_data),
		.o_syndrome(syn_s3)
	);

	//==================================================
	// locator and search
	//==================================================
	key_equation u_key_equation (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_s1       (syn_s1),
		.i_s3       (syn_s3),
		.i_syn_valid(syn_valid),
		.o_locator  (locator),
		.o_loc_valid(loc_valid)
	);

	chien_search u_chien_search (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_locator      (locator),
		.i_loc_valid    (loc_valid),
		.o_err_loc      (o_err_loc),
		.o_err_valid    (o_err_valid),
		.o_finish       (o_finish),
		.o_num_err      (o_num_err),
		.o_uncorrectable(o_uncorrectable)
	);

endmodule

`default_nettype wire

// ==== verification/tb_bch_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_bch_decoder import bch_pkg::*; ();

	localparam int BEAT_W = 8;
	localparam int NUM_BEATS = 64 / BEAT_W;
	localparam int NUM_BLOCKS = 40;
	localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 80 + 50;
	localparam int FINISH_LAT = NUM_BEATS + 66;    // beats, locator, 63 positions, strobes
	localparam int SEED = 32'h0a51_29af;
	localparam logic [6:0] M1_POLY = 7'b100_0011;  // x^6 + x + 1
	localparam logic [6:0] M3_POLY = 7'b101_0111;  // x^6 + x^4 + x^2 + x + 1

	logic              i_clk;
	logic              i_rst_n;
	logic              i_set;
	logic [BEAT_W-1:0] i_data;
	logic              o_ready;
	loc_t              o_err_loc;
	logic              o_err_valid;
	logic              o_finish;
	logic [1:0]        o_num_err;
	logic              o_uncorrectable;

	logic [12:0] gen_poly;    // g(x) = m1(x) * m3(x)
	logic [1:0]  exp_num;     // errors injected into the block in flight
	loc_t        exp_loc [2]; // ascending
	logic        exp_ready;
	logic [1:0]  err_idx;     // error strobes seen in this block
	int          since_accept;

	bch_decoder #(
		.BEAT_W(BEAT_W)
	) i_bch_decoder (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_set          (i_set),
		.i_data         (i_data),
		.o_ready        (o_ready),
		.o_err_loc      (o_err_loc),
		.o_err_valid    (o_err_valid),
		.o_finish       (o_finish),
		.o_num_err      (o_num_err),
		.o_uncorrectable(o_uncorrectable)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	//==================================================
	// helpers
	//==================================================
	task automatic report_failure(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	// carry-less product of two degree-6 polynomials
	function automatic logic [12:0] poly_mul(input logic [6:0] a, input logic [6:0] b);
		logic [12:0] p;
		p = '0;
		for (int i = 0; i < 7; i++) begin
			if (b[i]) begin
				p = p ^ (13'(a) << i);
			end
		end
		return p;
	endfunction

	// non-systematic codeword m(x) * g(x)
	function automatic logic [62:0] encode_message(input logic [50:0] msg);
		logic [62:0] cw;
		cw = '0;
		for (int i = 0; i < 51; i++) begin
			if (msg[i]) begin
				cw = cw ^ (63'(gen_poly) << i);
			end
		end
		return cw;
	endfunction

	// waits for ready, then streams one word with n_err bit flips
	task automatic send_block(input int n_err, input bit extra_set);
		logic [50:0] msg;
		logic [62:0] cw;
		logic [63:0] word;
		loc_t        p0;
		loc_t        p1;
		loc_t        tmp;
		msg = 51'({$urandom, $urandom});
		cw = encode_message(msg);
		p0 = loc_t'($urandom % CODE_N);
		p1 = loc_t'($urandom % CODE_N);
		while (p1 == p0) begin
			p1 = loc_t'($urandom % CODE_N);
		end
		if (p1 < p0) begin
			tmp = p0;
			p0 = p1;
			p1 = tmp;
		end
		if (n_err >= 1) begin
			cw[p0] = ~cw[p0];
		end
		if (n_err == 2) begin
			cw[p1] = ~cw[p1];
		end
		word = {1'b0, cw};  // bit 63 is padding
		do begin
			@(posedge i_clk);
		end while (!o_ready);
		i_set <= 1'b1;
		i_data <= word[63 -: BEAT_W];
		exp_num <= 2'(n_err);
		exp_loc[0] <= p0;
		exp_loc[1] <= p1;
		for (int k = 1; k < NUM_BEATS; k++) begin
			@(posedge i_clk);
			i_set <= extra_set && (k == 3);  // must be ignored while busy
			i_data <= word[63 - k * BEAT_W -: BEAT_W];
		end
		@(posedge i_clk);
		i_set <= 1'b0;
		i_data <= '0;
	endtask

	//==================================================
	// expected handshake state and strobe counts
	//==================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			exp_ready <= 1'b1;
			err_idx <= '0;
			since_accept <= 0;
		end else begin
			if (i_set && exp_ready) begin
				exp_ready <= 1'b0;
				err_idx <= '0;
				since_accept <= 1;
			end else begin
				if (o_finish) begin
					exp_ready <= 1'b1;  // ready back one cycle after finish
				end
				if (o_err_valid) begin
					err_idx <= err_idx + 1'b1;
				end
				if (!exp_ready) begin
					since_accept <= since_accept + 1;  // cycles since the set was taken
				end
			end
		end
	end

	a_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_ready == exp_ready)
		else report_failure($sformatf("o_ready is %0b, expected %0b", o_ready, exp_ready));

	a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		exp_ready |-> !o_err_valid && !o_finish)
		else report_failure("error or finish strobe while no block is in flight");

	a_err_count: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_err_valid |-> err_idx < exp_num)
		else report_failure($sformatf("extra error strobe at %0d, %0d expected in block",
			o_err_loc, exp_num));

	a_err_loc: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_err_valid |-> o_err_loc == exp_loc[err_idx[0]])
		else report_failure($sformatf("error location %0d, expected %0d",
			o_err_loc, exp_loc[err_idx[0]]));

	a_finish_num: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_finish |-> o_num_err == exp_num && err_idx == exp_num)
		else report_failure($sformatf("o_num_err %0d after %0d strobes, expected %0d",
			o_num_err, err_idx, exp_num));

	a_finish_corr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_finish |-> !o_uncorrectable)
		else report_failure("o_uncorrectable set on a correctable block");

	// a set taken while busy would restart the block and delay the finish
	a_finish_time: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_finish |-> since_accept == FINISH_LAT)
		else report_failure($sformatf("o_finish %0d cycles after set, expected %0d",
			since_accept, FINISH_LAT));

	//==================================================
	// stimulus
	//==================================================
	initial begin
		void'($urandom(SEED));
		gen_poly = poly_mul(M1_POLY, M3_POLY);
		i_rst_n = 1'b0;
		i_set = 1'b0;
		i_data = '0;
		exp_num = '0;
		exp_loc[0] = '0;
		exp_loc[1] = '0;
		repeat (4) @(posedge i_clk);
		i_rst_n <= 1'b1;
		send_block(0, 1'b1);  // clean word
		send_block(1, 1'b1);
		send_block(2, 1'b1);
		for (int b = 3; b < NUM_BLOCKS; b++) begin
			send_block(int'($urandom % 3), ($urandom % 4) == 0);
		end
		do begin
			@(posedge i_clk);
		end while (!o_ready);
		$display("Test completed successfully");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clk);
		$display("Watchdog expired after %0d cycles, the decoder stopped finishing blocks",
			WATCHDOG_CYCLES);
		$display("Test failed");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

// ==== bch_decoder.f ====
common/bch_pkg.sv
rtl/bch_control.sv
syndrome/syndrome_accum.sv
rtl/key_equation.sv
chien_search/chien_search.sv
rtl/bch_decoder.sv
verification/tb_bch_decoder.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_bch_decoder
FILELIST  ?= bch_decoder.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test completed successfully

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
